//--- design/mmu_pkg.sv
// ------------------------------------------------------------------
// Sv32-style widths, PTE bit positions and cause codes. No ASIDs and
// no G bit. The permission check ignores SUM and MXR.
// ------------------------------------------------------------------
package mmu_pkg;

    // address and page geometry
    localparam int VLEN     = 32;
    localparam int PLEN     = 34;
    localparam int PPN_W    = 22;
    localparam int VPN_W    = 10;
    localparam int OFFSET_W = 12;
    localparam int PTE_W    = 32;

    localparam int unsigned ITLB_ENTRIES = 4;
    localparam int unsigned DTLB_ENTRIES = 4;

    // page table entry flags, PPN in bits 31:10
    localparam int PTE_V       = 0;
    localparam int PTE_R       = 1;
    localparam int PTE_W_BIT   = 2;
    localparam int PTE_X       = 3;
    localparam int PTE_U       = 4;
    localparam int PTE_A       = 6;
    localparam int PTE_D       = 7;
    localparam int PTE_PPN_LSB = 10;

    localparam logic PRIV_U = 1'b0;
    localparam logic PRIV_S = 1'b1;

    localparam logic [3:0] CAUSE_INSTR_PF = 4'd12;
    localparam logic [3:0] CAUSE_LOAD_PF  = 4'd13;
    localparam logic [3:0] CAUSE_STORE_PF = 4'd15;

    localparam logic [1:0] ACC_EXEC  = 2'd0;
    localparam logic [1:0] ACC_READ  = 2'd1;
    localparam logic [1:0] ACC_WRITE = 2'd2;

    // one virtual address, split for a 4 KiB page or a 4 MiB megapage
    typedef union packed {
        struct packed {
            logic [VPN_W-1:0]    vpn1;
            logic [VPN_W-1:0]    vpn0;
            logic [OFFSET_W-1:0] offset;
        } view_4k;
        struct packed {
            logic [VPN_W-1:0]          vpn1;
            logic [VPN_W+OFFSET_W-1:0] offset;
        } view_mega;
    } vaddr_u;

    // leaf permission check for one access kind
    function automatic logic page_permits(input logic [PTE_W-1:0] pte,
                                          input logic             priv,
                                          input logic [1:0]       acc);
        logic ok;
        ok = pte[PTE_A] && (pte[PTE_U] ? (priv == PRIV_U) : (priv == PRIV_S));
        case (acc)
            ACC_EXEC:  ok = ok && pte[PTE_X];
            ACC_READ:  ok = ok && pte[PTE_R];
            ACC_WRITE: ok = ok && pte[PTE_W_BIT] && pte[PTE_D];
            default:   ok = 1'b0;
        endcase
        return ok;
    endfunction

endpackage

//--- design/mmu_if.sv
// ------------------------------------------------------------------
// TLB lookup and refill buses. Lookup answers combinationally.
// ------------------------------------------------------------------

// lookup from a translation path, also watched by the walker
interface tlb_lookup_if import mmu_pkg::*; ();
    logic             access;
    logic [VLEN-1:0]  vaddr;
    logic             hit;
    logic [PTE_W-1:0] pte;
    logic             is_mega;

    modport requester (output access, vaddr, input hit, pte, is_mega);
    modport tlb       (input access, vaddr, output hit, pte, is_mega);
    modport walker    (input access, vaddr, hit);
endinterface

// one-cycle refill pulse from the walker
interface tlb_refill_if import mmu_pkg::*; ();
    logic             valid;
    logic [VLEN-1:0]  vaddr;
    logic [PTE_W-1:0] pte;
    logic             is_mega;

    modport ptw (output valid, vaddr, pte, is_mega);
    modport tlb (input valid, vaddr, pte, is_mega);
endinterface

//--- design/mmu_tlb.sv
// ------------------------------------------------------------------
// Fully associative TLB, round-robin refill. ENTRIES must be a power
// of two and at least 2. Flush clears every entry.
// ------------------------------------------------------------------
module mmu_tlb import mmu_pkg::*; #(
    parameter int unsigned ENTRIES = 4
) (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      flush_i,
    tlb_lookup_if.tlb lookup,
    tlb_refill_if.tlb refill
);

    logic [ENTRIES-1:0]         valid_q;
    logic [ENTRIES-1:0]         mega_q;
    logic [VPN_W-1:0]           vpn1_q [ENTRIES];
    logic [VPN_W-1:0]           vpn0_q [ENTRIES];
    logic [PTE_W-1:0]           pte_q  [ENTRIES];
    logic [$clog2(ENTRIES)-1:0] repl_q;
    vaddr_u                     lu_va;
    vaddr_u                     rf_va;

    assign lu_va = lookup.vaddr;
    assign rf_va = refill.vaddr;

    // a megapage entry ignores vpn0
    always_comb begin
        lookup.hit     = 1'b0;
        lookup.pte     = '0;
        lookup.is_mega = 1'b0;
        for (int i = 0; i < ENTRIES; i++) begin
            if (valid_q[i] && (vpn1_q[i] == lu_va.view_mega.vpn1) &&
                (mega_q[i] || (vpn0_q[i] == lu_va.view_4k.vpn0))) begin
                lookup.hit     = lookup.access;
                lookup.pte     = pte_q[i];
                lookup.is_mega = mega_q[i];
            end
        end
    end

    // ------------------------------------------------------------------
    // valid bits and replacement pointer
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            repl_q  <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else if (refill.valid) begin
            valid_q[repl_q] <= 1'b1;
            if (int'(repl_q) == ENTRIES - 1) begin
                repl_q <= '0;
            end else begin
                repl_q <= repl_q + 1'b1;
            end
        end
    end

    // entry contents
    always_ff @(posedge clk_i) begin
        if (refill.valid) begin
            vpn1_q[repl_q] <= rf_va.view_4k.vpn1;
            vpn0_q[repl_q] <= rf_va.view_4k.vpn0;
            mega_q[repl_q] <= refill.is_mega;
            pte_q[repl_q]  <= refill.pte;
        end
    end

endmodule

//--- design/mmu_ptw.sv
// ------------------------------------------------------------------
// Two-level walker, read-only APB requester. pslverr is not handled
// and nothing is written back. Instruction misses win over data.
// ------------------------------------------------------------------
module mmu_ptw import mmu_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              satp_en_i,
    input  logic [PPN_W-1:0]  satp_ppn_i,
    tlb_lookup_if.walker      itlb,
    tlb_lookup_if.walker      dtlb,
    tlb_refill_if.ptw         itlb_refill,
    tlb_refill_if.ptw         dtlb_refill,
    output logic              itlb_error_o,
    output logic              dtlb_error_o,
    output logic              psel_o,
    output logic              penable_o,
    output logic [PLEN-1:0]   paddr_o,
    input  logic              pready_i,
    input  logic [PTE_W-1:0]  prdata_i
);

    logic            busy_q;
    logic            penable_q;
    logic            lvl_q;
    logic            idle_q;
    logic            side_q;
    vaddr_u          vaddr_q;
    logic [PLEN-1:0] paddr_q;

    logic   start_i;
    logic   start_d;
    logic   start;
    vaddr_u start_va;
    logic   resp;
    logic   pte_bad;
    logic   pte_leaf;
    logic   misaligned;
    logic   done_ok;
    logic   done_err;
    logic   descend;

    assign start_i  = satp_en_i && itlb.access && !itlb.hit;
    assign start_d  = satp_en_i && dtlb.access && !dtlb.hit;
    assign start    = !busy_q && !idle_q && (start_i || start_d);
    assign start_va = start_i ? itlb.vaddr : dtlb.vaddr;

    // ------------------------------------------------------------------
    // PTE decode on the response cycle
    // ------------------------------------------------------------------
    assign resp       = busy_q && penable_q && pready_i;
    assign pte_bad    = !prdata_i[PTE_V] || (prdata_i[PTE_W_BIT] && !prdata_i[PTE_R]);
    assign pte_leaf   = prdata_i[PTE_R] || prdata_i[PTE_X];
    // megapage needs ppn0 all zero
    assign misaligned = |prdata_i[PTE_PPN_LSB +: VPN_W];

    assign done_ok  = resp && !pte_bad && pte_leaf && (lvl_q || !misaligned);
    assign done_err = resp && (pte_bad || (pte_leaf && !lvl_q && misaligned) ||
                               (!pte_leaf && lvl_q));
    assign descend  = resp && !pte_bad && !pte_leaf && !lvl_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q    <= 1'b0;
            penable_q <= 1'b0;
            lvl_q     <= 1'b0;
            idle_q    <= 1'b0;
            side_q    <= 1'b0;
        end else begin
            idle_q <= done_ok || done_err;
            if (start) begin
                busy_q    <= 1'b1;
                penable_q <= 1'b0;
                lvl_q     <= 1'b0;
                side_q    <= start_i;
            end else if (busy_q) begin
                if (!penable_q) begin
                    penable_q <= 1'b1;
                end else if (pready_i) begin
                    // a pointer goes back to setup for the second read
                    penable_q <= 1'b0;
                    lvl_q     <= descend;
                    busy_q    <= descend;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start) begin
            vaddr_q <= start_va;
            paddr_q <= {satp_ppn_i, start_va.view_4k.vpn1, 2'b00};
        end else if (descend) begin
            paddr_q <= {prdata_i[PTE_W-1:PTE_PPN_LSB], vaddr_q.view_4k.vpn0, 2'b00};
        end
    end

    assign psel_o    = busy_q;
    assign penable_o = penable_q;
    assign paddr_o   = paddr_q;

    assign itlb_refill.valid   = done_ok && side_q;
    assign itlb_refill.vaddr   = vaddr_q;
    assign itlb_refill.pte     = prdata_i;
    assign itlb_refill.is_mega = !lvl_q;

    assign dtlb_refill.valid   = done_ok && !side_q;
    assign dtlb_refill.vaddr   = vaddr_q;
    assign dtlb_refill.pte     = prdata_i;
    assign dtlb_refill.is_mega = !lvl_q;

    assign itlb_error_o = done_err && side_q;
    assign dtlb_error_o = done_err && !side_q;

endmodule

//--- design/mmu_ifetch_xlate.sv
// ------------------------------------------------------------------
// Fetch translation, fully combinational. Only page faults are raised.
// ------------------------------------------------------------------
module mmu_ifetch_xlate import mmu_pkg::*; (
    input  logic             fetch_req_i,
    input  logic [VLEN-1:0]  fetch_vaddr_i,
    input  logic             satp_en_i,
    input  logic             priv_lvl_i,
    tlb_lookup_if.requester  lookup,
    input  logic             ptw_error_i,
    output logic             fetch_valid_o,
    output logic [PLEN-1:0]  fetch_paddr_o,
    output logic             fetch_ex_valid_o,
    output logic [3:0]       fetch_ex_cause_o,
    output logic [VLEN-1:0]  fetch_ex_tval_o
);

    vaddr_u va;
    logic   no_perm;

    assign lookup.access = fetch_req_i;
    assign lookup.vaddr  = fetch_vaddr_i;
    assign va            = fetch_vaddr_i;
    assign no_perm       = !page_permits(lookup.pte, priv_lvl_i, ACC_EXEC);

    always_comb begin
        // bare mode passes the address through
        fetch_valid_o    = fetch_req_i;
        fetch_paddr_o    = {{(PLEN-VLEN){1'b0}}, fetch_vaddr_i};
        fetch_ex_valid_o = 1'b0;
        if (satp_en_i) begin
            if (lookup.is_mega) begin
                fetch_paddr_o = {lookup.pte[PTE_W-1 -: PPN_W-VPN_W], va.view_mega.offset};
            end else begin
                fetch_paddr_o = {lookup.pte[PTE_W-1 -: PPN_W], va.view_4k.offset};
            end
            // a miss waits for refill or the walker error pulse
            fetch_valid_o    = fetch_req_i && (lookup.hit || ptw_error_i);
            fetch_ex_valid_o = fetch_req_i && ((lookup.hit && no_perm) || ptw_error_i);
        end
        fetch_ex_cause_o = fetch_ex_valid_o ? CAUSE_INSTR_PF : 4'd0;
        fetch_ex_tval_o  = fetch_ex_valid_o ? fetch_vaddr_i : '0;
    end

endmodule

//--- design/mmu_lsu_xlate.sv
// ------------------------------------------------------------------
// Load/store translation. Result comes one cycle after a DTLB hit; a
// walk fault is reported in the cycle of the walker error pulse.
// ------------------------------------------------------------------
module mmu_lsu_xlate import mmu_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             lsu_req_i,
    input  logic [VLEN-1:0]  lsu_vaddr_i,
    input  logic             lsu_is_store_i,
    input  logic             satp_en_i,
    input  logic             priv_lvl_i,
    tlb_lookup_if.requester  lookup,
    input  logic             ptw_error_i,
    output logic             lsu_dtlb_hit_o,
    output logic             lsu_valid_o,
    output logic [PLEN-1:0]  lsu_paddr_o,
    output logic             lsu_ex_valid_o,
    output logic [3:0]       lsu_ex_cause_o,
    output logic [VLEN-1:0]  lsu_ex_tval_o
);

    logic             req_q;
    vaddr_u           vaddr_q;
    logic             store_q;
    logic [PTE_W-1:0] pte_q;
    logic             mega_q;
    logic             perm_err;

    assign lookup.access = lsu_req_i;
    assign lookup.vaddr  = lsu_vaddr_i;

    // always ready when translation is off
    assign lsu_dtlb_hit_o = satp_en_i ? lookup.hit : 1'b1;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_q <= 1'b0;
        end else begin
            req_q <= lsu_req_i && lsu_dtlb_hit_o;
        end
    end

    always_ff @(posedge clk_i) begin
        vaddr_q <= lsu_vaddr_i;
        store_q <= lsu_is_store_i;
        pte_q   <= lookup.pte;
        mega_q  <= lookup.is_mega;
    end

    // ------------------------------------------------------------------
    // second cycle: address and permission from the registered hit
    // ------------------------------------------------------------------
    assign perm_err = satp_en_i &&
                      !page_permits(pte_q, priv_lvl_i, store_q ? ACC_WRITE : ACC_READ);

    always_comb begin
        lsu_paddr_o = {{(PLEN-VLEN){1'b0}}, vaddr_q};
        if (satp_en_i) begin
            if (mega_q) begin
                lsu_paddr_o = {pte_q[PTE_W-1 -: PPN_W-VPN_W], vaddr_q.view_mega.offset};
            end else begin
                lsu_paddr_o = {pte_q[PTE_W-1 -: PPN_W], vaddr_q.view_4k.offset};
            end
        end
        lsu_valid_o    = req_q || ptw_error_i;
        lsu_ex_valid_o = 1'b0;
        lsu_ex_cause_o = 4'd0;
        lsu_ex_tval_o  = '0;
        if (ptw_error_i) begin
            // the faulting request is still held on the inputs
            lsu_ex_valid_o = 1'b1;
            lsu_ex_cause_o = lsu_is_store_i ? CAUSE_STORE_PF : CAUSE_LOAD_PF;
            lsu_ex_tval_o  = lsu_vaddr_i;
        end else if (req_q && perm_err) begin
            lsu_ex_valid_o = 1'b1;
            lsu_ex_cause_o = store_q ? CAUSE_STORE_PF : CAUSE_LOAD_PF;
            lsu_ex_tval_o  = vaddr_q;
        end
    end

endmodule

//--- design/mmu_top.sv
// ------------------------------------------------------------------
// MMU top: two TLBs, one walker, fetch and load/store paths.
// priv_lvl_i and satp_* must stay stable while a request is held.
// ------------------------------------------------------------------
module mmu_top import mmu_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              satp_en_i,
    input  logic [PPN_W-1:0]  satp_ppn_i,
    input  logic              priv_lvl_i,
    input  logic              flush_i,
    // fetch
    input  logic              fetch_req_i,
    input  logic [VLEN-1:0]   fetch_vaddr_i,
    output logic              fetch_valid_o,
    output logic [PLEN-1:0]   fetch_paddr_o,
    output logic              fetch_ex_valid_o,
    output logic [3:0]        fetch_ex_cause_o,
    output logic [VLEN-1:0]   fetch_ex_tval_o,
    // load/store
    input  logic              lsu_req_i,
    input  logic [VLEN-1:0]   lsu_vaddr_i,
    input  logic              lsu_is_store_i,
    output logic              lsu_dtlb_hit_o,
    output logic              lsu_valid_o,
    output logic [PLEN-1:0]   lsu_paddr_o,
    output logic              lsu_ex_valid_o,
    output logic [3:0]        lsu_ex_cause_o,
    output logic [VLEN-1:0]   lsu_ex_tval_o,
    // APB read requester
    output logic              psel_o,
    output logic              penable_o,
    output logic [PLEN-1:0]   paddr_o,
    input  logic              pready_i,
    input  logic [PTE_W-1:0]  prdata_i
);

    logic itlb_error;
    logic dtlb_error;

    tlb_lookup_if itlb_lu ();
    tlb_lookup_if dtlb_lu ();
    tlb_refill_if itlb_rf ();
    tlb_refill_if dtlb_rf ();

    mmu_tlb #(.ENTRIES(ITLB_ENTRIES)) u_itlb (
        .clk_i, .rst_ni, .flush_i, .lookup(itlb_lu.tlb), .refill(itlb_rf.tlb)
    );

    mmu_tlb #(.ENTRIES(DTLB_ENTRIES)) u_dtlb (
        .clk_i, .rst_ni, .flush_i, .lookup(dtlb_lu.tlb), .refill(dtlb_rf.tlb)
    );

    mmu_ptw u_ptw (
        .clk_i, .rst_ni, .satp_en_i, .satp_ppn_i,
        .itlb(itlb_lu.walker), .dtlb(dtlb_lu.walker),
        .itlb_refill(itlb_rf.ptw), .dtlb_refill(dtlb_rf.ptw),
        .itlb_error_o(itlb_error), .dtlb_error_o(dtlb_error),
        .psel_o, .penable_o, .paddr_o, .pready_i, .prdata_i
    );

    mmu_ifetch_xlate u_ifetch (
        .fetch_req_i, .fetch_vaddr_i, .satp_en_i, .priv_lvl_i,
        .lookup(itlb_lu.requester), .ptw_error_i(itlb_error),
        .fetch_valid_o, .fetch_paddr_o, .fetch_ex_valid_o, .fetch_ex_cause_o,
        .fetch_ex_tval_o
    );

    mmu_lsu_xlate u_lsu (
        .clk_i, .rst_ni, .lsu_req_i, .lsu_vaddr_i, .lsu_is_store_i, .satp_en_i,
        .priv_lvl_i, .lookup(dtlb_lu.requester), .ptw_error_i(dtlb_error),
        .lsu_dtlb_hit_o, .lsu_valid_o, .lsu_paddr_o, .lsu_ex_valid_o,
        .lsu_ex_cause_o, .lsu_ex_tval_o
    );

endmodule

//--- dv/mmu_checker.sv
// ----------------------------------------------------------------------
// APB and reset assertions, bound into mmu_top
// ----------------------------------------------------------------------
module mmu_checker import mmu_pkg::*; (
    input logic            clk_i,
    input logic            rst_ni,
    input logic            psel_o,
    input logic            penable_o,
    input logic [PLEN-1:0] paddr_o,
    input logic            pready_i,
    input logic            lsu_valid_o
);

    // bus idle while in reset and on the first cycle out of it
    a_reset_idle: assert property (@(posedge clk_i)
        (!rst_ni || $rose(rst_ni)) |-> (!psel_o && !penable_o))
        else $error("APB active during or just after reset");

    a_enable_sel: assert property (@(posedge clk_i) disable iff (!rst_ni)
        penable_o |-> psel_o)
        else $error("penable_o without psel_o");

    // wait state holds the access
    a_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (psel_o && penable_o && !pready_i) |=> (penable_o && $stable(paddr_o)))
        else $error("paddr_o changed during a wait state");

    a_lsu_reset: assert property (@(posedge clk_i)
        $rose(rst_ni) |-> !lsu_valid_o)
        else $error("lsu_valid_o high right after reset");

endmodule

//--- dv/mmu_tb.sv
// ----------------------------------------------------------------------
// Random MMU test against a page-table model. One request side at a
// time; every translated page is remapped and flushed before its use.
// ----------------------------------------------------------------------
module mmu_tb import mmu_pkg::*; ();

    localparam int N_BARE = 20;
    localparam int N_ITER = 60;
    localparam int N_REQ  = N_BARE + 2 * N_ITER;
    localparam logic [PPN_W-1:0] ROOT_PPN = 22'h00100;

    logic clk_i = 1'b0;
    logic rst_ni, satp_en_i, priv_lvl_i, flush_i;
    logic fetch_req_i, lsu_req_i, lsu_is_store_i, pready_i;
    logic [VLEN-1:0] fetch_vaddr_i, lsu_vaddr_i, fetch_ex_tval_o, lsu_ex_tval_o;
    logic [PTE_W-1:0] prdata_i;
    logic fetch_valid_o, fetch_ex_valid_o, lsu_dtlb_hit_o, lsu_valid_o, lsu_ex_valid_o;
    logic psel_o, penable_o;
    logic [PLEN-1:0] fetch_paddr_o, lsu_paddr_o, paddr_o;
    logic [3:0] fetch_ex_cause_o, lsu_ex_cause_o;

    logic [PTE_W-1:0] pt_mem [logic [PLEN-1:0]];
    logic [PLEN-1:0]  exp_apb [$];
    int               wait_cnt;

    mmu_top dut0 (.satp_ppn_i(ROOT_PPN), .*);
    bind mmu_top mmu_checker u_checker (.*);

    always #10 clk_i = ~clk_i;

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_paddr(input string name, input logic [PLEN-1:0] act, exp);
        if (act !== exp)
            stop_with_error($sformatf("Fail t=%0t %s got=%h exp=%h", $time, name, act, exp));
    endtask

    task automatic check_exc(input string name, input logic v, input logic [3:0] c,
                             input logic [VLEN-1:0] t, input logic ev,
                             input logic [3:0] ec, input logic [VLEN-1:0] et);
        if ({v, c, t} !== {ev, ec, et})
            stop_with_error($sformatf("Fail t=%0t %s got=%b/%0d/%h exp=%b/%0d/%h",
                                      $time, name, v, c, t, ev, ec, et));
    endtask

    task automatic check_apb_addr(input logic [PLEN-1:0] act, exp);
        if (act !== exp)
            stop_with_error($sformatf("Fail t=%0t paddr_o got=%h exp=%h", $time, act, exp));
    endtask

    function automatic logic [PTE_W-1:0] read_pte(input logic [PLEN-1:0] a);
        return pt_mem.exists(a) ? pt_mem[a] : '0;
    endfunction

    function automatic logic allowed(input logic [PTE_W-1:0] p, input logic priv,
                                     input logic [1:0] acc);
        logic kind_ok;
        kind_ok = (acc == ACC_EXEC) ? p[PTE_X] :
                  (acc == ACC_READ) ? p[PTE_R] : (p[PTE_W_BIT] && p[PTE_D]);
        return p[PTE_A] && (p[PTE_U] == (priv == PRIV_U)) && kind_ok;
    endfunction

    // reference walk that can also queue the APB read addresses
    task automatic model_walk(input logic [VLEN-1:0] va, input logic record,
                              output logic ok, output logic [PLEN-1:0] pa,
                              output logic [PTE_W-1:0] p);
        vaddr_u          v;
        logic [PLEN-1:0] a;
        logic            mega;
        v = va;
        mega = 1'b1;
        a = {ROOT_PPN, v.view_4k.vpn1, 2'b00};
        if (record) exp_apb.push_back(a);
        p = read_pte(a);
        if (p[PTE_V] && !p[PTE_W_BIT] && !p[PTE_R] && !p[PTE_X]) begin
            mega = 1'b0;
            a = {p[PTE_W-1:PTE_PPN_LSB], v.view_4k.vpn0, 2'b00};
            if (record) exp_apb.push_back(a);
            p = read_pte(a);
        end
        ok = p[PTE_V] && !(p[PTE_W_BIT] && !p[PTE_R]) && (p[PTE_R] || p[PTE_X]) &&
             (!mega || p[PTE_PPN_LSB +: VPN_W] == '0);
        pa = mega ? {p[PTE_W-1 -: 12], v.view_mega.offset} : {p[PTE_W-1:10], v.view_4k.offset};
    endtask

    // new random mapping for the page of va
    task automatic remap(input logic [VLEN-1:0] va);
        vaddr_u           v;
        logic [7:0]       f;
        logic [PPN_W-1:0] tbl;
        logic [PLEN-1:0]  a1;
        int               kind;
        v = va;
        f = 8'($urandom);
        f[PTE_V] = ($urandom % 8) != 0;
        f[PTE_A] = ($urandom % 6) != 0;
        f[PTE_U] = (priv_lvl_i == PRIV_U) ^ (($urandom % 6) == 0);
        if (!f[PTE_R] && !f[PTE_X]) f[PTE_R] = 1'b1;
        tbl = 22'h00200 + 22'($urandom % 16);
        a1 = {ROOT_PPN, v.view_4k.vpn1, 2'b00};
        kind = $urandom % 5;
        case (kind)
            0: pt_mem[a1] = {12'($urandom), 10'h000, 2'b00, f};
            1: pt_mem[a1] = {12'($urandom), 10'($urandom | 1), 2'b00, f};
            4: pt_mem[a1] = {31'($urandom), 1'b0};
            default: begin
                pt_mem[a1] = {tbl, 2'b00, 8'h01};
                pt_mem[{tbl, v.view_4k.vpn0, 2'b00}] = {22'($urandom), 2'b00, f};
            end
        endcase
    endtask

    task automatic do_fetch(input logic [VLEN-1:0] va, input logic cached, output logic ok);
        logic [PLEN-1:0]  pa;
        logic [PTE_W-1:0] p;
        logic             ex;
        ok = 1'b0;
        pa = {2'b00, va};
        ex = 1'b0;
        if (satp_en_i) begin
            model_walk(va, !cached, ok, pa, p);
            ex = !ok || !allowed(p, priv_lvl_i, ACC_EXEC);
        end
        @(negedge clk_i);
        fetch_req_i = 1'b1;
        fetch_vaddr_i = va;
        #1;
        if ((cached || !satp_en_i) && !fetch_valid_o)
            stop_with_error("fetch_valid_o missing in the request cycle of a hit");
        while (!fetch_valid_o) begin
            @(negedge clk_i);
            #1;
        end
        check_exc("fetch_ex", fetch_ex_valid_o, fetch_ex_cause_o, fetch_ex_tval_o,
                  ex, ex ? CAUSE_INSTR_PF : 4'd0, ex ? va : '0);
        if (!ex) check_paddr("fetch_paddr_o", fetch_paddr_o, pa);
        @(negedge clk_i);
        fetch_req_i = 1'b0;
    endtask

    task automatic do_lsu(input logic [VLEN-1:0] va, input logic st, input logic cached,
                          output logic ok);
        logic [PLEN-1:0]  pa;
        logic [PTE_W-1:0] p;
        logic             ex;
        ok = 1'b0;
        pa = {2'b00, va};
        ex = 1'b0;
        if (satp_en_i) begin
            model_walk(va, !cached, ok, pa, p);
            ex = !ok || !allowed(p, priv_lvl_i, st ? ACC_WRITE : ACC_READ);
        end
        @(negedge clk_i);
        lsu_req_i = 1'b1;
        lsu_vaddr_i = va;
        lsu_is_store_i = st;
        #1;
        if ((cached || !satp_en_i) && !lsu_dtlb_hit_o)
            stop_with_error("lsu_dtlb_hit_o missing in the request cycle of a hit");
        while (!lsu_dtlb_hit_o && !lsu_valid_o) begin
            @(negedge clk_i);
            #1;
        end
        if (lsu_dtlb_hit_o) begin
            @(negedge clk_i);
            lsu_req_i = 1'b0;
            #1;
            if (!lsu_valid_o) stop_with_error("lsu_valid_o not one cycle after the hit");
        end
        check_exc("lsu_ex", lsu_ex_valid_o, lsu_ex_cause_o, lsu_ex_tval_o, ex,
                  !ex ? 4'd0 : st ? CAUSE_STORE_PF : CAUSE_LOAD_PF, ex ? va : '0);
        if (!ex) check_paddr("lsu_paddr_o", lsu_paddr_o, pa);
        @(negedge clk_i);
        lsu_req_i = 1'b0;
    endtask

    // ----------------------------------------------------------------------
    // APB page-table memory with 0 to 3 wait cycles
    // ----------------------------------------------------------------------
    always @(negedge clk_i) begin
        pready_i = 1'b0;
        if (rst_ni && psel_o && penable_o) begin
            if (wait_cnt == 0) begin
                pready_i = 1'b1;
                prdata_i = read_pte(paddr_o);
                if (exp_apb.size() == 0) stop_with_error("APB read while none was expected");
                check_apb_addr(paddr_o, exp_apb.pop_front());
            end else begin
                wait_cnt = wait_cnt - 1;
            end
        end else begin
            wait_cnt = $urandom % 4;
        end
    end

    initial begin
        #(N_REQ * 40 * 20);
        stop_with_error("timeout, a request never completed");
    end

    initial begin
        logic [VLEN-1:0] va;
        logic            cached;
        logic            side;
        void'($urandom(32'hb2bd2d60));
        {rst_ni, satp_en_i, priv_lvl_i, flush_i, fetch_req_i, lsu_req_i} = '0;
        {lsu_is_store_i, pready_i, fetch_vaddr_i, lsu_vaddr_i, prdata_i} = '0;
        wait_cnt = 0;
        repeat (10) @(negedge clk_i);
        rst_ni = 1'b1;
        for (int i = 0; i < N_BARE; i++) begin
            if (i % 2 == 0) do_fetch($urandom, 1'b0, cached);
            else do_lsu($urandom, 1'($urandom), 1'b0, cached);
        end
        satp_en_i = 1'b1;
        for (int i = 0; i < N_ITER; i++) begin
            va = $urandom;
            // small page pool, so a remapped page was often cached before the flush
            va[VLEN-1 -: VPN_W] = 10'($urandom % 4);
            va[OFFSET_W +: VPN_W] = 10'($urandom % 4);
            side = 1'($urandom);
            priv_lvl_i = 1'($urandom);
            remap(va);
            flush_i = 1'b1;
            @(negedge clk_i);
            flush_i = 1'b0;
            cached = 1'b0;
            // second access to the same page hits when the walk succeeded
            repeat (2) begin
                va[OFFSET_W-1:0] = 12'($urandom);
                if (side) do_fetch(va, cached, cached);
                else do_lsu(va, 1'($urandom), cached, cached);
                if (exp_apb.size() != 0) stop_with_error("walk ended before all expected reads");
            end
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- vlog.f
design/mmu_pkg.sv
design/mmu_if.sv
design/mmu_tlb.sv
design/mmu_ptw.sv
design/mmu_ifetch_xlate.sv
design/mmu_lsu_xlate.sv
design/mmu_top.sv
dv/mmu_checker.sv
dv/mmu_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the MMU testbench with Verilator.
# The exit status of the simulation is the test result.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module mmu_tb \
    -f vlog.f -o mmu_sim
./obj_dir/mmu_sim
